//--- Bender.yml
package:
  name: pixel_mix

sources:
  - include_dirs:
      - common
    files:
      - common/pixelMixPkg.sv
      - linebuffer/lineBufferRam.sv
      - linebuffer/lineBufferPair.sv
      - logic/fixPixelLatch.sv
      - logic/paletteAddrMux.sv
      - logic/resetWatchdog.sv
      - logic/pixelMixTop.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/pixelMix_props.sv
      - testbench/pixelMixTb.sv

//--- build.f
+incdir+common
common/pixelMixPkg.sv
linebuffer/lineBufferRam.sv
linebuffer/lineBufferPair.sv
logic/fixPixelLatch.sv
logic/paletteAddrMux.sv
logic/resetWatchdog.sv
logic/pixelMixTop.sv
testbench/pixelMix_props.sv
testbench/pixelMixTb.sv

//--- common/pixelMixPkg.sv
/* Pixel mix types
   Shared vector types and the watchdog state encoding */
`include "pixelMix_macros.svh"

package pixelMixPkg;

	// Palette number in the upper bits, color in the low nibble
	typedef logic [`PALETTE_W-1:0] paletteAddr;

	// Position on a line
	typedef logic [`X_W-1:0] pixelX;

	// Zero is transparent
	typedef logic [`COLOR_W-1:0] colorIndex;

	typedef logic [`SPR_PAL_W-1:0] spritePalette;
	typedef logic [`FIX_PAL_W-1:0] fixPalette;

	// Watchdog FSM
	typedef enum logic
	{
		wdCount,
		wdReset
	} watchdogState;

endpackage

//--- common/pixelMix_macros.svh
/* Pixel mix sizes
   Field widths, line buffer depth and watchdog constants */
`ifndef PIXELMIX_MACROS_SVH
`define PIXELMIX_MACROS_SVH

// Field widths
`define PALETTE_W 12
`define X_W 8
`define COLOR_W 4
`define SPR_PAL_W 8
`define FIX_PAL_W 4

// One entry per pixel on a line
`define LINE_DEPTH 256

// Watchdog
`define WD_KICK_ADDR 12'h3C0
`define WD_LIMIT 200
`define WD_PULSE 8
`define WD_CNT_W 8

`endif

//--- linebuffer/lineBufferPair.sv
/* Sprite line buffer pair
   Ping-pong stores, one filled with sprite pixels while the other is shown
   and cleared behind the display counter */
`timescale 1ns/1ps
`include "pixelMix_macros.svh"

module lineBufferPair
(
	input logic CK1,
	input logic arstN,
	input logic xLoad,
	input pixelMixPkg::pixelX xStart,
	input logic spriteWrite,
	input pixelMixPkg::spritePalette spritePal,
	input pixelMixPkg::colorIndex spriteColor,
	input logic lineSwap,
	input logic pixelStep,
	output pixelMixPkg::paletteAddr spriteAddr,
	output logic spriteValid
);
	import pixelMixPkg::*;

	// Bank being written, the other one is displayed
	logic bankSel;
	// Bank that was read at the last step
	logic readBank;

	pixelX writeCount;
	pixelX dispCount;

	paletteAddr spriteData;
	logic spriteStore;

	logic writeEn0;
	logic writeEn1;
	pixelX writeAddr0;
	pixelX writeAddr1;
	paletteAddr writeData0;
	paletteAddr writeData1;
	paletteAddr readData0;
	paletteAddr readData1;

	assign spriteData = {spritePal, spriteColor};
	// Transparent pixels never reach the store
	assign spriteStore = spriteWrite && (|spriteColor);

	// Bank 0 takes sprites when selected, display clears otherwise
	assign writeEn0 = bankSel ? pixelStep : spriteStore;
	assign writeAddr0 = bankSel ? dispCount : writeCount;
	assign writeData0 = bankSel ? paletteAddr'(0) : spriteData;

	// Bank 1 mirrors it
	assign writeEn1 = bankSel ? spriteStore : pixelStep;
	assign writeAddr1 = bankSel ? writeCount : dispCount;
	assign writeData1 = bankSel ? spriteData : paletteAddr'(0);

	lineBufferRam bank0_i
	(
		.CK1(CK1),
		.writeEn(writeEn0),
		.writeAddr(writeAddr0),
		.writeData(writeData0),
		.readAddr(dispCount),
		.readData(readData0)
	);

	lineBufferRam bank1_i
	(
		.CK1(CK1),
		.writeEn(writeEn1),
		.writeAddr(writeAddr1),
		.writeData(writeData1),
		.readAddr(dispCount),
		.readData(readData1)
	);

	assign spriteAddr = readBank ? readData1 : readData0;

	// Write position, load wins over a write strobe
	always_ff @(posedge CK1 or negedge arstN)
	begin
		if (!arstN)
			writeCount <= '0;
		else if (xLoad)
			writeCount <= xStart;
		else if (spriteWrite)
			writeCount <= writeCount + 1'b1;
	end

	// Bank roles and display position
	always_ff @(posedge CK1 or negedge arstN)
	begin
		if (!arstN)
		begin
			bankSel <= 1'b0;
			dispCount <= '0;
			readBank <= 1'b1;
			spriteValid <= 1'b0;
		end
		else
		begin
			spriteValid <= pixelStep;
			if (pixelStep)
				readBank <= ~bankSel;
			if (lineSwap)
			begin
				bankSel <= ~bankSel;
				dispCount <= '0;
			end
			else if (pixelStep)
				dispCount <= dispCount + 1'b1;
		end
	end

endmodule

//--- linebuffer/lineBufferRam.sv
/* Line buffer store
   One line of palette addresses, one write port, registered read */
`timescale 1ns/1ps
`include "pixelMix_macros.svh"

module lineBufferRam
(
	input logic CK1,
	input logic writeEn,
	input pixelMixPkg::pixelX writeAddr,
	input pixelMixPkg::paletteAddr writeData,
	input pixelMixPkg::pixelX readAddr,
	output pixelMixPkg::paletteAddr readData
);
	import pixelMixPkg::*;

	paletteAddr mem [0:`LINE_DEPTH-1];

	// Start empty in simulation
	initial
	begin
		for (int i = 0; i < `LINE_DEPTH; i++)
			mem[i] = '0;
	end

	// Read returns the old entry when the same cycle writes it
	always_ff @(posedge CK1)
	begin
		if (writeEn)
			mem[writeAddr] <= writeData;
		readData <= mem[readAddr];
	end

endmodule

//--- logic/fixPixelLatch.sv
/* Fix pixel latch
   Holds a fix pixel pair and palette, picks one pixel and flags opacity */
`timescale 1ns/1ps
`include "pixelMix_macros.svh"

module fixPixelLatch
(
	input logic CK1,
	input logic arstN,
	input logic fixLoad,
	input logic [2*`COLOR_W-1:0] fixData,
	input pixelMixPkg::fixPalette fixPal,
	input logic fixOdd,
	output pixelMixPkg::paletteAddr fixAddr,
	output logic fixOpaque
);
	import pixelMixPkg::*;

	// Two pixels, odd one in the high nibble
	logic [2*`COLOR_W-1:0] pairReg;
	fixPalette palReg;
	colorIndex fixColor;

	always_ff @(posedge CK1 or negedge arstN)
	begin
		if (!arstN)
		begin
			pairReg <= '0;
			palReg <= '0;
		end
		else if (fixLoad)
		begin
			pairReg <= fixData;
			palReg <= fixPal;
		end
	end

	assign fixColor = fixOdd ? pairReg[2*`COLOR_W-1:`COLOR_W] : pairReg[`COLOR_W-1:0];

	// Color 0 lets the sprite layer through
	assign fixOpaque = |fixColor;

	// Fix palettes live in the bottom 16 palettes
	assign fixAddr = {{(`PALETTE_W-`FIX_PAL_W-`COLOR_W){1'b0}}, palReg, fixColor};

endmodule

//--- logic/paletteAddrMux.sv
/* Palette address select
   CPU, blanking, fix then sprite priority onto the palette address */
`timescale 1ns/1ps
`include "pixelMix_macros.svh"

module paletteAddrMux
(
	input logic CK1,
	input logic arstN,
	input logic spriteValid,
	input pixelMixPkg::paletteAddr spriteAddr,
	input pixelMixPkg::paletteAddr fixAddr,
	input logic fixOpaque,
	input logic blank,
	input logic cpuPalSel,
	input pixelMixPkg::paletteAddr cpuAddr,
	output pixelMixPkg::paletteAddr paletteAddr
);

	// Port name shadows the type here
	pixelMixPkg::paletteAddr videoReg;
	pixelMixPkg::paletteAddr videoNext;

	// Blank over fix, fix only when opaque
	always_comb
	begin
		if (blank)
			videoNext = '0;
		else if (fixOpaque)
			videoNext = fixAddr;
		else
			videoNext = spriteAddr;
	end

	// Advances once per displayed pixel
	always_ff @(posedge CK1 or negedge arstN)
	begin
		if (!arstN)
			videoReg <= '0;
		else if (spriteValid)
			videoReg <= videoNext;
	end

	// CPU access takes the bus right away
	assign paletteAddr = cpuPalSel ? cpuAddr : videoReg;

endmodule

//--- logic/pixelMixTop.sv
/* Pixel mix top
   Sprite line buffers, fix latch, palette select and reset watchdog */
`timescale 1ns/1ps
`include "pixelMix_macros.svh"

module pixelMixTop
(
	input logic CK1,
	input logic arstN,
	input logic xLoad,
	input pixelMixPkg::pixelX xStart,
	input logic spriteWrite,
	input pixelMixPkg::spritePalette spritePal,
	input pixelMixPkg::colorIndex spriteColor,
	input logic lineSwap,
	input logic pixelStep,
	input logic fixLoad,
	input logic [2*`COLOR_W-1:0] fixData,
	input pixelMixPkg::fixPalette fixPal,
	input logic fixOdd,
	input logic blank,
	input logic cpuPalSel,
	input logic cpuWrite,
	input pixelMixPkg::paletteAddr cpuAddr,
	output pixelMixPkg::paletteAddr paletteAddr,
	output logic systemResetN,
	output logic haltN
);

	// Sprite path
	pixelMixPkg::paletteAddr spriteAddr;
	logic spriteValid;

	// Fix path
	pixelMixPkg::paletteAddr fixAddr;
	logic fixOpaque;

	lineBufferPair lineBuf_i
	(
		.CK1(CK1),
		.arstN(arstN),
		.xLoad(xLoad),
		.xStart(xStart),
		.spriteWrite(spriteWrite),
		.spritePal(spritePal),
		.spriteColor(spriteColor),
		.lineSwap(lineSwap),
		.pixelStep(pixelStep),
		.spriteAddr(spriteAddr),
		.spriteValid(spriteValid)
	);

	fixPixelLatch fix_i
	(
		.CK1(CK1),
		.arstN(arstN),
		.fixLoad(fixLoad),
		.fixData(fixData),
		.fixPal(fixPal),
		.fixOdd(fixOdd),
		.fixAddr(fixAddr),
		.fixOpaque(fixOpaque)
	);

	paletteAddrMux mux_i
	(
		.CK1(CK1),
		.arstN(arstN),
		.spriteValid(spriteValid),
		.spriteAddr(spriteAddr),
		.fixAddr(fixAddr),
		.fixOpaque(fixOpaque),
		.blank(blank),
		.cpuPalSel(cpuPalSel),
		.cpuAddr(cpuAddr),
		.paletteAddr(paletteAddr)
	);

	// Same CPU address feeds the kick decode
	resetWatchdog wd_i
	(
		.CK1(CK1),
		.arstN(arstN),
		.cpuWrite(cpuWrite),
		.cpuAddr(cpuAddr),
		.systemResetN(systemResetN)
	);

	// Halt follows reset
	assign haltN = systemResetN;

endmodule

//--- logic/resetWatchdog.sv
/* Reset watchdog
   Counts cycles between CPU kicks and pulses system reset on timeout */
`timescale 1ns/1ps
`include "pixelMix_macros.svh"

module resetWatchdog
(
	input logic CK1,
	input logic arstN,
	input logic cpuWrite,
	input pixelMixPkg::paletteAddr cpuAddr,
	output logic systemResetN
);
	import pixelMixPkg::*;

	watchdogState state;
	logic [`WD_CNT_W-1:0] count;
	logic kick;

	// Only a write to the kick address counts
	assign kick = cpuWrite && (cpuAddr == `WD_KICK_ADDR);

	always_ff @(posedge CK1 or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= wdCount;
			count <= '0;
		end
		else
		begin
			case (state)
				wdCount:
				begin
					if (kick)
						count <= '0;
					else if (count == `WD_LIMIT - 1)
					begin
						// Timed out
						state <= wdReset;
						count <= '0;
					end
					else
						count <= count + 1'b1;
				end
				wdReset:
				begin
					// Kicks ignored while reset is out
					if (count == `WD_PULSE - 1)
					begin
						state <= wdCount;
						count <= '0;
					end
					else
						count <= count + 1'b1;
				end
				default:
				begin
					state <= wdCount;
					count <= '0;
				end
			endcase
		end
	end

	assign systemResetN = (state != wdReset);

endmodule

//--- testbench/pixelMixTb.sv
/* Pixel mix testbench
   Table of sprite, fix and CPU rows checked against a buffer model, then watchdog timing */
`timescale 1ns/1ps
`include "pixelMix_macros.svh"

module pixelMixTb;
	import pixelMixPkg::*;

	// Display window per line, keeps the run inside the timeout budget
	localparam int dispLen = 128;

	typedef struct packed
	{
		pixelX xA;
		logic [7:0] lenA;
		spritePalette palA;
		colorIndex colA;
		pixelX xB;
		logic [7:0] lenB;
		spritePalette palB;
		colorIndex colB;
		logic rnd;
		logic [7:0] fixData;
		fixPalette fixPal;
		logic fixOdd;
		logic fixLoad;
		logic blank;
		logic cpuSel;
		paletteAddr cpuAddr;
	} stimRow;

	logic CK1;
	logic arstN;
	logic xLoad;
	pixelX xStart;
	logic spriteWrite;
	spritePalette spritePal;
	colorIndex spriteColor;
	logic lineSwap;
	logic pixelStep;
	logic fixLoad;
	logic [7:0] fixData;
	fixPalette fixPal;
	logic fixOdd;
	logic blank;
	logic cpuPalSel;
	logic cpuWrite;
	paletteAddr cpuAddr;
	paletteAddr palAddrOut;
	logic systemResetN;
	logic haltN;

	stimRow rows[$];
	string rowNames[$];

	// Reference model of both line stores and the video register
	paletteAddr modelBuf [0:1][0:`LINE_DEPTH-1];
	logic wrBank;
	logic [7:0] fixPair;
	fixPalette fixPalM;
	paletteAddr videoModel;

	int cycleCount = 0;
	int timeoutLimit = 0;
	int errorCount = 0;

	pixelMixTop dut_i
	(
		.CK1(CK1),
		.arstN(arstN),
		.xLoad(xLoad),
		.xStart(xStart),
		.spriteWrite(spriteWrite),
		.spritePal(spritePal),
		.spriteColor(spriteColor),
		.lineSwap(lineSwap),
		.pixelStep(pixelStep),
		.fixLoad(fixLoad),
		.fixData(fixData),
		.fixPal(fixPal),
		.fixOdd(fixOdd),
		.blank(blank),
		.cpuPalSel(cpuPalSel),
		.cpuWrite(cpuWrite),
		.cpuAddr(cpuAddr),
		.paletteAddr(palAddrOut),
		.systemResetN(systemResetN),
		.haltN(haltN)
	);

	initial
		CK1 = 1'b0;

	always #50 CK1 = ~CK1;

	// Hang guard
	always @(posedge CK1)
	begin
		cycleCount++;
		if (timeoutLimit != 0 && cycleCount >= timeoutLimit)
		begin
			$display("timeout after %0d cycles, the run did not finish", cycleCount);
			$display("SOME TESTS FAILED");
			$fatal(1, "run stopped by timeout");
		end
	end

	// Any failed property of the bound checker
	always @(dut_i.props_i.failCount)
	begin
		if (dut_i.props_i.failCount != 0)
		begin
			$display("a property bound to the DUT failed");
			$display("SOME TESTS FAILED");
			$fatal(1, "property check failed");
		end
	end

	// Inputs change 10 ns after the edge
	task automatic nextCycle;
		@(posedge CK1);
		#10;
	endtask

	task automatic checkValue(input string name, input int exp, input int act);
		assert (act == exp)
		else
		begin
			errorCount++;
			$display("mismatch %s expected 0x%03h actual 0x%03h", name, exp, act);
			$display("SOME TESTS FAILED");
			$fatal(1, "value check failed");
		end
	endtask

	task automatic checkTrue(input bit cond, input string what);
		assert (cond)
		else
		begin
			errorCount++;
			$display("%s", what);
			$display("SOME TESTS FAILED");
			$fatal(1, "check failed");
		end
	endtask

	task automatic addRow
	(
		input string name,
		input logic [7:0] xA, lenA, palA,
		input logic [3:0] colA,
		input logic [7:0] xB, lenB, palB,
		input logic [3:0] colB,
		input logic rnd,
		input logic [7:0] fixDataIn,
		input logic [3:0] fixPalIn,
		input logic fixOddIn, fixLoadIn, blankIn, cpuSelIn,
		input logic [11:0] cpuAddrIn
	);
		stimRow row;
		row = {xA, lenA, palA, colA, xB, lenB, palB, colB, rnd,
			fixDataIn, fixPalIn, fixOddIn, fixLoadIn, blankIn, cpuSelIn, cpuAddrIn};
		rows.push_back(row);
		rowNames.push_back(name);
	endtask

	// One sprite run into the write bank, color 0 stays transparent
	task automatic writeRun(input pixelX x, input int len, input spritePalette pal,
		input colorIndex col, input logic rnd);
		pixelX pos;
		spritePalette p;
		colorIndex c;
		if (len > 0)
		begin
			nextCycle;
			xLoad = 1'b1;
			xStart = x;
			pos = x;
			for (int k = 0; k < len; k++)
			begin
				nextCycle;
				xLoad = 1'b0;
				p = rnd ? spritePalette'($urandom) : pal;
				c = rnd ? colorIndex'($urandom) : col;
				spriteWrite = 1'b1;
				spritePal = p;
				spriteColor = c;
				if (c != 0)
					modelBuf[wrBank][pos] = {p, c};
				pos++;
			end
			nextCycle;
			spriteWrite = 1'b0;
		end
	endtask

	// Fix setup, sprite writes, swap, then one display pass
	task automatic runRow(input int r);
		stimRow row;
		paletteAddr expQ[$];
		paletteAddr exp;
		colorIndex fixColor;
		paletteAddr fixAddrM;
		logic fixOpaqueM;
		logic rdBank;
		logic selNow;
		row = rows[r];
		nextCycle;
		cpuPalSel = 1'b0;
		fixLoad = row.fixLoad;
		fixData = row.fixData;
		fixPal = row.fixPal;
		fixOdd = row.fixOdd;
		blank = row.blank;
		cpuAddr = row.cpuAddr;
		if (row.fixLoad)
		begin
			fixPair = row.fixData;
			fixPalM = row.fixPal;
		end
		nextCycle;
		fixLoad = 1'b0;
		writeRun(row.xA, row.lenA, row.palA, row.colA, row.rnd);
		writeRun(row.xB, row.lenB, row.palB, row.colB, row.rnd);
		nextCycle;
		lineSwap = 1'b1;
		wrBank = ~wrBank;
		rdBank = ~wrBank;

		// Odd pixel in the high nibble, upper nibble of the address 0
		fixColor = row.fixOdd ? fixPair[7:4] : fixPair[3:0];
		fixOpaqueM = (fixColor != 0);
		fixAddrM = {4'h0, fixPalM, fixColor};

		for (int i = 0; i < dispLen + 2; i++)
		begin
			nextCycle;
			lineSwap = 1'b0;
			pixelStep = (i < dispLen);
			// CPU grabs the bus on every other pixel
			selNow = row.cpuSel && (i % 2 == 1);
			cpuPalSel = selNow;
			if (i < dispLen)
			begin
				if (row.blank)
					exp = '0;
				else if (fixOpaqueM)
					exp = fixAddrM;
				else
					exp = modelBuf[rdBank][i];
				modelBuf[rdBank][i] = '0;
				expQ.push_back(exp);
			end
			// Step result shows two edges later
			if (i >= 2)
				videoModel = expQ.pop_front();
			#5;
			checkValue($sformatf("%s pixel %0d", rowNames[r], i),
				selNow ? row.cpuAddr : videoModel, palAddrOut);
		end
	endtask

	task automatic checkWatchdog;
		int idle;
		int lowCount;
		nextCycle;
		cpuPalSel = 1'b0;
		blank = 1'b0;
		while (!systemResetN)
			nextCycle;

		// Kicks spaced below the limit, with stray writes between
		for (int k = 0; k < 3; k++)
		begin
			cpuWrite = 1'b1;
			cpuAddr = `WD_KICK_ADDR;
			for (int c = 0; c < `WD_LIMIT - 50; c++)
			begin
				nextCycle;
				cpuWrite = (c % 3 == 0);
				cpuAddr = `WD_KICK_ADDR ^ (12'h1 << (c % 12));
				checkTrue(systemResetN && haltN,
					"system reset or halt went low although the watchdog was kicked");
			end
			nextCycle;
		end

		// Last kick, then writes every cycle to addresses one bit off
		cpuWrite = 1'b1;
		cpuAddr = `WD_KICK_ADDR;
		nextCycle;
		cpuAddr = `WD_KICK_ADDR ^ 12'h800;
		idle = 0;
		while (systemResetN)
		begin
			nextCycle;
			cpuAddr = `WD_KICK_ADDR ^ (12'h1 << (idle % 12));
			idle++;
		end
		checkTrue(idle >= `WD_LIMIT - 2 && idle <= `WD_LIMIT + 2,
			$sformatf("watchdog timed out %0d cycles after the last kick", idle));

		lowCount = 0;
		while (!systemResetN)
		begin
			checkTrue(!haltN, "haltN stayed high during the system reset pulse");
			lowCount++;
			nextCycle;
		end
		cpuWrite = 1'b0;
		checkValue("watchdog pulse length", `WD_PULSE, lowCount);
	endtask

	initial
	begin
		void'($urandom(5));
		arstN = 1'b0;
		xLoad = 1'b0;
		xStart = '0;
		spriteWrite = 1'b0;
		spritePal = '0;
		spriteColor = '0;
		lineSwap = 1'b0;
		pixelStep = 1'b0;
		fixLoad = 1'b0;
		fixData = '0;
		fixPal = '0;
		fixOdd = 1'b0;
		blank = 1'b0;
		cpuPalSel = 1'b0;
		cpuWrite = 1'b0;
		cpuAddr = '0;
		for (int b = 0; b < 2; b++)
			for (int a = 0; a < `LINE_DEPTH; a++)
				modelBuf[b][a] = '0;
		wrBank = 1'b0;
		fixPair = '0;
		fixPalM = '0;
		videoModel = '0;

		//     name               xA  lenA palA  colA xB lenB palB  colB rnd fix  pal odd ld bl cpu
		addRow("spriteRun",       10, 8,   'h21, 5,   0, 0,   0,    0,   0, 'h00, 0, 0, 1, 0, 0, 'h000);
		addRow("emptyOther",      0,  0,   0,    0,   0, 0,   0,    0,   0, 'h00, 0, 0, 0, 0, 0, 'h000);
		addRow("secondPass",      0,  0,   0,    0,   0, 0,   0,    0,   0, 'h00, 0, 0, 0, 0, 0, 'h000);
		addRow("transparentSkip", 40, 12,  'h33, 7,  44, 6,   'h44, 0,   0, 'h00, 0, 0, 0, 0, 0, 'h000);
		addRow("overwrite",       40, 10,  'h35, 3,  43, 4,   'h56, 9,   0, 'h00, 0, 0, 0, 0, 0, 'h000);
		addRow("fixEvenClear",    0,  20,  0,    0,   0, 0,   0,    0,   1, 'hA0, 6, 0, 1, 0, 0, 'h000);
		addRow("fixOddOpaque",    0,  20,  0,    0,   0, 0,   0,    0,   1, 'hA0, 6, 1, 1, 0, 0, 'h000);
		addRow("fixEvenOpaque",   64, 16,  'h7E, 'hC, 0, 0,   0,    0,   0, 'h0B, 3, 0, 1, 0, 0, 'h000);
		addRow("blankLine",       0,  30,  0,    0,   0, 0,   0,    0,   1, 'h0B, 3, 0, 0, 1, 0, 'h000);
		addRow("cpuOverride",     5,  30,  0,    0,   0, 0,   0,    0,   1, 'h00, 0, 0, 1, 0, 1, 'h5A5);
		timeoutLimit = rows.size() * 300 + 2 * `WD_LIMIT;

		repeat (8) @(posedge CK1);
		#10;
		arstN = 1'b1;

		for (int r = 0; r < rows.size(); r++)
			runRow(r);
		checkWatchdog;

		if (errorCount == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- testbench/pixelMix_props.sv
/* Pixel mix assertions
   Halt, reset pulse and CPU palette override checks bound to the top */
`timescale 1ns/1ps
`include "pixelMix_macros.svh"

module pixelMixProps
(
	input logic CK1,
	input logic arstN,
	input logic systemResetN,
	input logic haltN,
	input logic cpuPalSel,
	input pixelMixPkg::paletteAddr cpuAddr,
	input pixelMixPkg::paletteAddr paletteAddr
);

	// Number of failed properties so far
	int failCount = 0;

	// Halt is a copy of system reset
	haltFollowsReset: assert property (@(posedge CK1) disable iff (!arstN)
		haltN == systemResetN)
		else
		begin
			failCount++;
			$error("haltN differs from systemResetN");
		end

	// Low for exactly the pulse length, then released
	resetPulseLength: assert property (@(posedge CK1) disable iff (!arstN)
		$fell(systemResetN) |-> !systemResetN [*`WD_PULSE] ##1 systemResetN)
		else
		begin
			failCount++;
			$error("system reset pulse has the wrong length");
		end

	// CPU access wins without delay
	cpuOverride: assert property (@(posedge CK1) disable iff (!arstN)
		cpuPalSel |-> paletteAddr == cpuAddr)
		else
		begin
			failCount++;
			$error("paletteAddr does not follow cpuAddr under cpuPalSel");
		end

endmodule

bind pixelMixTop pixelMixProps props_i
(
	.CK1(CK1),
	.arstN(arstN),
	.systemResetN(systemResetN),
	.haltN(haltN),
	.cpuPalSel(cpuPalSel),
	.cpuAddr(cpuAddr),
	.paletteAddr(paletteAddr)
);
